// ==== xbar_pkg.sv ====
// Stream crossbar size constants.
// Holds the port counts and field widths that the demultiplexers, the
// arbiters, the spill registers and the top level all have to agree on.
// The select and index widths are derived, so only the counts and the
// payload width are meant to be edited.

package xbar_pkg;

  // Number of input streams entering the crossbar.
  localparam int unsigned NUM_INP = 4;

  // Number of output streams leaving the crossbar.
  localparam int unsigned NUM_OUT = 4;

  // Width of one payload word in bits.
  // The payload is carried through unchanged from input to output.
  localparam int unsigned DATA_W = 16;

  // Width of the output select that travels with every input word.
  // A single output still needs one select bit to keep the port legal.
  localparam int unsigned SEL_W = (NUM_OUT > 1) ? $clog2(NUM_OUT) : 1;

  // Width of the input index reported alongside every output word.
  // It names the input that the word was taken from.
  localparam int unsigned IDX_W = (NUM_INP > 1) ? $clog2(NUM_INP) : 1;

  // With four inputs and four outputs both derived widths come out as
  // two bits, which matches the 2-bit select of the input streams.
  // Every select value is then a real output, so the demultiplexers
  // never see an out-of-range select.
  // The arbiters count their rotating pointer modulo NUM_INP, so a count
  // that is not a power of two would still wrap correctly.
  // The widths above are used in the module headers as scoped names and
  // in the module bodies through a wildcard import.

endpackage

// ==== stream_demux.sv ====
// Stream demultiplexer for one crossbar input.
// Turns the output select of the input into a one-hot request towards
// the output arbiters and returns the grant of the selected output.

`timescale 1ns/1ps

module stream_demux (
  input  logic                        inp_valid_i,
  input  logic [xbar_pkg::SEL_W-1:0]  inp_sel_i,
  output logic                        inp_ready_o,
  output logic [xbar_pkg::NUM_OUT-1:0] oup_valid_o,
  input  logic [xbar_pkg::NUM_OUT-1:0] oup_ready_i
);

  import xbar_pkg::*;

  // Only the selected output sees a request.
  // All other request bits stay low, so an input never competes for an
  // output that it does not address.
  always_comb begin
    for (int unsigned j = 0; j < NUM_OUT; j++) begin
      oup_valid_o[j] = inp_valid_i && (inp_sel_i == SEL_W'(j));
    end
  end

  // The input is ready exactly when the selected output grants it.
  // The arbiter only grants a requesting input, so a high ready here
  // always coincides with a high valid on the same input.
  // The select is held stable by the source while valid waits for ready,
  // so the returned grant belongs to the word that is being offered.
  assign inp_ready_o = oup_ready_i[inp_sel_i];

  // This block holds no state.
  // Its request output follows valid and select in the same cycle, and
  // its ready follows the arbiter grant in the same cycle.
  // The arbiters decide combinationally from these requests, so the
  // decode adds no cycle to the path from input to output.
  // Ready is never a function of this input's own valid alone, which
  // keeps the handshake free of loops through the decode stage.
  // A source that drops valid without a transfer is outside the stream
  // rule and is not guarded against here.

endmodule

// ==== rr_arbiter.sv ====
// Round-robin arbiter for one crossbar output.
// Picks one of the requesting inputs by rotating priority, locks that
// choice while the output stage is not ready, and forwards the payload
// and the index of the winner.

`timescale 1ns/1ps

module rr_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              flush_i,
  input  logic [xbar_pkg::NUM_INP-1:0]                      req_i,
  output logic [xbar_pkg::NUM_INP-1:0]                      gnt_o,
  input  logic [xbar_pkg::NUM_INP-1:0][xbar_pkg::DATA_W-1:0] data_i,
  output logic                                              req_o,
  input  logic                                              gnt_i,
  output logic [xbar_pkg::DATA_W-1:0]                       data_o,
  output logic [xbar_pkg::IDX_W-1:0]                        idx_o
);

  import xbar_pkg::*;

  // Priority pointer.
  // The input it names has the highest priority in the next decision.
  logic [IDX_W-1:0] ptr_q;

  // Lock state.
  // While set, the decision stored in lock_idx_q overrides the search.
  logic             lock_q;
  logic [IDX_W-1:0] lock_idx_q;

  // Winner of the current cycle and the pointer value that follows it.
  logic [IDX_W-1:0] win_idx;
  logic [IDX_W-1:0] ptr_nxt;

  // A word moves from the winner into the output stage.
  logic             xfer;

  // Search for the first requesting input at or after the pointer.
  // The loop walks the inputs in rotated order and keeps the first hit.
  // With no request at all the pointer itself is named, which is harmless
  // because its request bit is then low as well.
  always_comb begin : proc_pick
    logic [IDX_W-1:0] cand;
    logic             found;
    found   = 1'b0;
    cand    = ptr_q;
    win_idx = ptr_q;
    for (int unsigned k = 0; k < NUM_INP; k++) begin
      cand = IDX_W'((ptr_q + k) % NUM_INP);
      if (!found && req_i[cand]) begin
        found   = 1'b1;
        win_idx = cand;
      end
    end
    // A locked decision wins over the search.
    // The locked input keeps requesting until its word is taken, so the
    // output stays stable while the output stage is full.
    if (lock_q) begin
      win_idx = lock_idx_q;
    end
  end

  // The output request is the request of the chosen input.
  assign req_o = req_i[win_idx];

  // A transfer into the output stage needs a request and its grant.
  assign xfer = req_o && gnt_i;

  // Only the winner is granted, and only when the output stage accepts.
  // All other inputs see their grant low and keep waiting.
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = xfer;
  end

  // Payload and source index of the winner.
  assign data_o = data_i[win_idx];
  assign idx_o  = win_idx;

  // Next pointer position is one past the winner, wrapping at the end.
  assign ptr_nxt = (win_idx == IDX_W'(NUM_INP - 1)) ? '0 : win_idx + 1'b1;

  // Pointer and lock registers.
  // Flush behaves like reset for the arbitration state only.
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (xfer) begin
        // The winner has been served, so the rotation moves on and the
        // lock is released for the next decision.
        ptr_q  <= ptr_nxt;
        lock_q <= 1'b0;
      end else if (req_o) begin
        // A request is waiting for the output stage.
        // The current winner is held until the transfer happens.
        lock_q     <= 1'b1;
        lock_idx_q <= win_idx;
      end
    end
  end

  // Timing summary.
  // Requests reach the grants in the same cycle, so the decode and the
  // arbitration add no latency.
  // The grant towards the inputs depends on gnt_i, which comes from a
  // register in the output stage, so no combinational loop is formed.
  // With all inputs requesting and gnt_i high every cycle, the pointer
  // steps through the inputs in order and each input is served once per
  // round.
  // An input that stops requesting is skipped on the next decision
  // without costing a cycle.

endmodule

// ==== spill_register.sv ====
// Output spill register for one crossbar output.
// Two registered slots cut the combinational ready path from the output
// port back to the arbiter while still passing one word per cycle.

`timescale 1ns/1ps

module spill_register (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  input  logic [xbar_pkg::DATA_W-1:0] data_i,
  input  logic [xbar_pkg::IDX_W-1:0]  idx_i,
  output logic                       valid_o,
  input  logic                       ready_i,
  output logic [xbar_pkg::DATA_W-1:0] data_o,
  output logic [xbar_pkg::IDX_W-1:0]  idx_o
);

  import xbar_pkg::*;

  // Slot A drives the output port.
  logic              a_full_q;
  logic [DATA_W-1:0] a_data_q;
  logic [IDX_W-1:0]  a_idx_q;

  // Slot B holds a word that arrived while slot A was blocked.
  logic              b_full_q;
  logic [DATA_W-1:0] b_data_q;
  logic [IDX_W-1:0]  b_idx_q;

  // Handshake events of the current cycle.
  logic accept;
  logic drain;
  logic load_a;
  logic load_b;
  logic move_b;

  // Ready towards the arbiter comes straight from a flop.
  // As long as slot B is free, any arriving word has somewhere to go.
  assign ready_o = ~b_full_q;

  assign accept = valid_i && !b_full_q;
  assign drain  = a_full_q && ready_i;

  // A new word goes to slot A when A is empty or is being emptied now.
  // Otherwise it is caught by slot B.
  assign load_a = accept && (!a_full_q || ready_i);
  assign load_b = accept && a_full_q && !ready_i;

  // The word in slot B moves up as soon as slot A drains.
  // No new word is accepted in that cycle, so order is kept.
  assign move_b = b_full_q && drain;

  // Fill flags.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (load_a || move_b) begin
        a_full_q <= 1'b1;
      end else if (drain) begin
        a_full_q <= 1'b0;
      end
      if (load_b) begin
        b_full_q <= 1'b1;
      end else if (move_b) begin
        b_full_q <= 1'b0;
      end
    end
  end

  // Slot contents.
  // The flags above say which slot holds a valid word.
  always_ff @(posedge clk_i) begin
    if (move_b) begin
      a_data_q <= b_data_q;
      a_idx_q  <= b_idx_q;
    end else if (load_a) begin
      a_data_q <= data_i;
      a_idx_q  <= idx_i;
    end
    if (load_b) begin
      b_data_q <= data_i;
      b_idx_q  <= idx_i;
    end
  end

  // Output port.
  // A word accepted on one edge is visible from the next cycle on.
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;
  assign idx_o   = a_idx_q;

endmodule

// ==== stream_xbar.sv ====
// Fully connected stream crossbar.
// Each input word is steered by its select to one of the outputs, every
// output arbitrates its requesters round-robin, and a spill register per
// output drives the ports together with the index of the source input.

`timescale 1ns/1ps

module stream_xbar (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              flush_i,
  input  logic [xbar_pkg::NUM_INP-1:0][xbar_pkg::DATA_W-1:0] data_i,
  input  logic [xbar_pkg::NUM_INP-1:0][xbar_pkg::SEL_W-1:0]  sel_i,
  input  logic [xbar_pkg::NUM_INP-1:0]                      valid_i,
  output logic [xbar_pkg::NUM_INP-1:0]                      ready_o,
  output logic [xbar_pkg::NUM_OUT-1:0][xbar_pkg::DATA_W-1:0] data_o,
  output logic [xbar_pkg::NUM_OUT-1:0][xbar_pkg::IDX_W-1:0]  idx_o,
  output logic [xbar_pkg::NUM_OUT-1:0]                      valid_o,
  input  logic [xbar_pkg::NUM_OUT-1:0]                      ready_i
);

  import xbar_pkg::*;

  // Requests and grants as seen from the input side.
  // Index order is input first, then output.
  logic [NUM_INP-1:0][NUM_OUT-1:0] inp_valid;
  logic [NUM_INP-1:0][NUM_OUT-1:0] inp_ready;

  // The same requests and grants as seen from the output side.
  // Index order is output first, then input.
  logic [NUM_OUT-1:0][NUM_INP-1:0] out_valid;
  logic [NUM_OUT-1:0][NUM_INP-1:0] out_ready;

  // Decode stage with one demultiplexer per input.
  for (genvar i = 0; i < NUM_INP; i++) begin : gen_inp
    stream_demux i_stream_demux (
      .inp_valid_i (valid_i[i]),
      .inp_sel_i   (sel_i[i]),
      .inp_ready_o (ready_o[i]),
      .oup_valid_o (inp_valid[i]),
      .oup_ready_i (inp_ready[i])
    );

    // Transpose the handshake between the two sides of the crossbar.
    for (genvar j = 0; j < NUM_OUT; j++) begin : gen_cross
      assign out_valid[j][i] = inp_valid[i][j];
      assign inp_ready[i][j] = out_ready[j][i];
    end
  end

  // Execute and result stages with one arbiter and one spill register
  // per output.
  for (genvar j = 0; j < NUM_OUT; j++) begin : gen_oup
    logic              arb_valid;
    logic              arb_ready;
    logic [DATA_W-1:0] arb_data;
    logic [IDX_W-1:0]  arb_idx;

    // Every arbiter sees all input payloads and picks one of them.
    rr_arbiter i_rr_arbiter (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .flush_i (flush_i),
      .req_i   (out_valid[j]),
      .gnt_o   (out_ready[j]),
      .data_i  (data_i),
      .req_o   (arb_valid),
      .gnt_i   (arb_ready),
      .data_o  (arb_data),
      .idx_o   (arb_idx)
    );

    // The spill register drives the output port of this lane.
    spill_register i_spill_register (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (arb_valid),
      .ready_o (arb_ready),
      .data_i  (arb_data),
      .idx_i   (arb_idx),
      .valid_o (valid_o[j]),
      .ready_i (ready_i[j]),
      .data_o  (data_o[j]),
      .idx_o   (idx_o[j])
    );
  end

endmodule

// ==== tb_stream_xbar.sv ====
// Testbench for the stream crossbar.
// Reads routed words from the test data file, drives the four inputs with
// random gaps, applies random back-pressure on the outputs and checks each
// delivered word against one expected queue per input/output pair.
// A last phase checks the round-robin order on one output after a flush.

`timescale 1ns/1ps

module tb_stream_xbar;

  import xbar_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RST_CYCLES   = 5;
  localparam int SEED         = 82;
  localparam int TDATA_DEPTH  = 128;
  localparam int BLOCK_OUT    = 3;
  localparam int BLOCK_CYCLES = 24;
  localparam int FAIR_OUT     = 2;
  localparam int RDY_OFF      = 0;
  localparam int RDY_RANDOM   = 1;
  localparam int RDY_HIGH     = 2;

  logic                            clk_i;
  logic                            rst_i;
  logic                            flush_i;
  logic [NUM_INP-1:0][DATA_W-1:0]  data_i;
  logic [NUM_INP-1:0][SEL_W-1:0]   sel_i;
  logic [NUM_INP-1:0]              valid_i;
  logic [NUM_INP-1:0]              ready_o;
  logic [NUM_OUT-1:0][DATA_W-1:0]  data_o;
  logic [NUM_OUT-1:0][IDX_W-1:0]   idx_o;
  logic [NUM_OUT-1:0]              valid_o;
  logic [NUM_OUT-1:0]              ready_i;

  // Raw image of the test data file.
  // Word 0 and word 1 hold the entry counts, then three words per entry.
  logic [31:0]       tdata [TDATA_DEPTH];
  // Words still to be sent per input, in send order.
  logic [DATA_W-1:0] src_data [NUM_INP][$];
  logic [SEL_W-1:0]  src_sel  [NUM_INP][$];
  // Expected words, one queue per pair at index input * NUM_OUT + output.
  logic [DATA_W-1:0] exp_q [NUM_INP*NUM_OUT][$];

  int n_route    = 0;
  int n_fair     = 0;
  int n_words    = 0;
  int pending    = 0;
  int fair_cnt   = 0;
  int other_cnt  = 0;
  int block_left = 0;
  int rdy_mode   = RDY_OFF;
  bit drive_en   = 1'b0;
  bit no_gaps    = 1'b0;
  bit fair_on    = 1'b0;
  bit in_block   = 1'b0;

  // Handshake state sampled on the falling edge, used on the next rising one.
  logic [NUM_INP-1:0] took_q = '0;
  logic [NUM_OUT-1:0] hold_pend = '0;
  logic [DATA_W-1:0]  hold_data [NUM_OUT];
  logic [IDX_W-1:0]   hold_idx  [NUM_OUT];

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  stream_xbar i_dut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .data_i  (data_i),
    .sel_i   (sel_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_o  (data_o),
    .idx_o   (idx_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic print_mismatch(input string sig, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
    $display("[FAIL] time %0t ns: %s expected %0h, actual %0h", $time, sig, exp_val, act_val);
    abort_run();
  endtask

  task automatic explain_error(input string what);
    $display("Error at time %0t ns: %s", $time, what);
    abort_run();
  endtask

  // Moves test data entries into the send lists and the expected queues.
  task automatic load_words(input int first, input int count);
    int          base;
    int unsigned inp;
    int unsigned oup;
    for (int e = 0; e < count; e++) begin
      base = 2 + 3 * (first + e);
      inp  = tdata[base];
      oup  = tdata[base + 1];
      assert (inp < NUM_INP && oup < NUM_OUT)
        else explain_error($sformatf("test data entry %0d names a missing port", first + e));
      src_data[inp].push_back(DATA_W'(tdata[base + 2]));
      src_sel[inp].push_back(SEL_W'(oup));
      exp_q[inp * NUM_OUT + oup].push_back(DATA_W'(tdata[base + 2]));
      pending++;
    end
  endtask

  // Stimulus on the rising edge.
  // Ready and input words share one block, so the random sequence is fixed.
  always @(posedge clk_i) begin
    logic [NUM_OUT-1:0] rdy;
    rdy      = '0;
    in_block = (rdy_mode == RDY_RANDOM) && (block_left > 0);
    if (rdy_mode == RDY_RANDOM) begin
      rdy = NUM_OUT'($urandom);
      // During the block window one output is kept stalled.
      if (in_block) begin
        rdy[BLOCK_OUT] = 1'b0;
        block_left--;
      end
    end else if (rdy_mode == RDY_HIGH) begin
      rdy = '1;
    end
    ready_i <= rdy;
    if (drive_en) begin
      for (int i = 0; i < NUM_INP; i++) begin
        if (took_q[i]) begin
          void'(src_data[i].pop_front());
          void'(src_sel[i].pop_front());
        end
        // A word still waiting for ready stays untouched.
        if (!valid_i[i] || took_q[i]) begin
          if (src_data[i].size() > 0 && (no_gaps || $urandom_range(3, 0) != 0)) begin
            valid_i[i] <= 1'b1;
            data_i[i]  <= src_data[i][0];
            sel_i[i]   <= src_sel[i][0];
          end else begin
            valid_i[i] <= 1'b0;
          end
        end
      end
    end
  end

  // Checks on the falling edge, where all handshake signals are settled.
  always @(negedge clk_i) begin
    int                key;
    logic [DATA_W-1:0] exp_word;
    if (!rst_i) begin
      for (int j = 0; j < NUM_OUT; j++) begin
        // A stalled word must still be offered unchanged.
        if (hold_pend[j]) begin
          assert (valid_o[j])
            else explain_error($sformatf("output %0d dropped valid before its word was taken", j));
          assert (data_o[j] == hold_data[j])
            else print_mismatch($sformatf("data_o[%0d]", j), 32'(hold_data[j]), 32'(data_o[j]));
          assert (idx_o[j] == hold_idx[j])
            else print_mismatch($sformatf("idx_o[%0d]", j), 32'(hold_idx[j]), 32'(idx_o[j]));
        end
        if (valid_o[j] && ready_i[j]) begin
          key = int'(idx_o[j]) * NUM_OUT + j;
          assert (exp_q[key].size() > 0)
            else explain_error($sformatf("output %0d delivered a word that input %0d never sent",
                                         j, idx_o[j]));
          exp_word = exp_q[key].pop_front();
          pending--;
          assert (data_o[j] == exp_word)
            else print_mismatch($sformatf("data_o[%0d]", j), 32'(exp_word), 32'(data_o[j]));
          // After the flush the pointer starts at input 0 and steps one past
          // each winner, so with every input requesting the order is 0, 1, 2, 3.
          if (fair_on && j == FAIR_OUT) begin
            assert (idx_o[j] == IDX_W'(fair_cnt % NUM_INP))
              else print_mismatch($sformatf("idx_o[%0d]", j), 32'(fair_cnt % NUM_INP),
                                  32'(idx_o[j]));
            fair_cnt++;
          end
          if (in_block && j != BLOCK_OUT) begin
            other_cnt++;
          end
        end
        hold_pend[j] = valid_o[j] && !ready_i[j];
        hold_data[j] = data_o[j];
        hold_idx[j]  = idx_o[j];
      end
      took_q = valid_i & ready_o;
    end
  end

  initial begin
    rst_i    = 1'b1;
    flush_i  = 1'b0;
    data_i   = '0;
    sel_i    = '0;
    valid_i  = '0;
    ready_i  = '0;
    void'($urandom(SEED));
    $readmemh("stream_xbar_testdata.txt", tdata);
    n_route = tdata[0];
    n_fair  = tdata[1];
    n_words = n_route + n_fair;
    assert (n_route > 0 && n_fair > 0 && n_fair % NUM_INP == 0)
      else explain_error("the test data file holds no usable entry counts");
    // All outputs stay idle through reset and the first cycle after it.
    for (int c = 0; c < RST_CYCLES; c++) begin
      @(posedge clk_i);
      if (c == RST_CYCLES - 1) begin
        rst_i <= 1'b0;
      end
      @(negedge clk_i);
      assert (valid_o == '0) else print_mismatch("valid_o", 32'(0), 32'(valid_o));
    end
    load_words(0, n_route);
    @(negedge clk_i);
    assert (valid_o == '0) else print_mismatch("valid_o", 32'(0), 32'(valid_o));
    // Routing under random back-pressure, starting with one output blocked.
    rdy_mode   = RDY_RANDOM;
    block_left = BLOCK_CYCLES;
    drive_en   = 1'b1;
    do @(negedge clk_i); while (block_left > 0 || in_block);
    assert (other_cnt > 0)
      else explain_error("the other outputs stalled while one output was held not ready");
    do @(posedge clk_i); while (pending > 0);
    // Fairness on one output with all inputs requesting and ready held high.
    @(negedge clk_i);
    drive_en = 1'b0;
    rdy_mode = RDY_HIGH;
    no_gaps  = 1'b1;
    fair_on  = 1'b1;
    load_words(n_route, n_fair);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    drive_en = 1'b1;
    do @(posedge clk_i); while (pending > 0);
    // Every expected word has arrived, so the outputs have to fall silent.
    // A spill register holds at most two words, so two idle cycles expose a
    // duplicated or stuck word.
    for (int c = 0; c < 2; c++) begin
      @(negedge clk_i);
      assert (valid_o == '0) else print_mismatch("valid_o", 32'(0), 32'(valid_o));
    end
    $display("Result: PASSED");
    $finish;
  end

  // Watchdog sized from the number of words in the test data.
  initial begin
    #1;
    #((n_words + 200) * 4 * CLK_PERIOD);
    explain_error($sformatf("timeout, %0d words were not all delivered, the crossbar hangs",
                            n_words));
  end

endmodule

// ==== stream_xbar_testdata.txt ====
// Columns: input number, output select, 16-bit payload, all in hex.
// The first data line holds the routing entry count and the fairness entry count.
// Entry counts: 20 routing words, 8 fairness words.
14 08
// Routing block. Input 0 starts with three words for output 3.
0 3 A001
1 0 B101
2 1 C201
3 2 D301
0 3 A002
1 1 B102
2 2 C202
3 0 D302
0 3 A003
1 2 B103
2 0 C203
3 1 D303
0 0 A004
1 3 B104
2 3 C204
3 3 D304
0 1 A005
1 0 B105
2 2 C205
3 1 D305
// Fairness block. Every input sends two words to output 2.
0 2 F001
1 2 F101
2 2 F201
3 2 F301
0 2 F002
1 2 F102
2 2 F202
3 2 F302

// ==== build.f ====
xbar_pkg.sv
stream_demux.sv
rr_arbiter.sv
spill_register.sv
stream_xbar.sv
tb_stream_xbar.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the crossbar testbench with Verilator and runs it from the project root.
# The run counts as passed only if the pass line shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_stream_xbar \
  -f build.f -o sim_stream_xbar &&
./obj_dir/sim_stream_xbar | tee /dev/stderr | grep "Result: PASSED" > /dev/null &&
echo "Simulation finished without errors" ||
{ echo "Simulation did not pass"; exit 1; }
